// File: src/prngPkg.sv
// shared widths, types and constants for the random victim unit
// the cipher layers are only defined for a 64-bit LFSR state
// LfsrMask is a maximal-length Galois mask, so any nonzero seed works
// the all-zero state is a lock-up state and must never be loaded

package prngPkg;

  //////////////////////////////
  // lfsr
  //////////////////////////////

  // state width, fixed by the 64-bit block of the cipher
  localparam int unsigned LfsrWidth = 64;

  // lfsr state, seed and scrambled word all share this type
  typedef logic [LfsrWidth-1:0] lfsrState_t;

  // galois feedback taps, msb set so the shifted-in bit follows bit 0
  localparam lfsrState_t LfsrMask = 64'h8000_0000_0000_19E2;

  // reset state, also used in place of a zero seed
  localparam lfsrState_t LfsrRstSeed = '1;

  //////////////////////////////
  // cipher
  //////////////////////////////

  // number of sbox + permutation rounds, no key addition
  localparam int unsigned CipherLayers = 2;

  typedef logic [3:0] nibble_t;
  typedef logic [5:0] bitIdx_t;

  // present sbox, indexed by the input nibble
  localparam nibble_t Sbox4 [16] = '{
    4'hC, 4'h5, 4'h6, 4'hB, 4'h9, 4'h0, 4'hA, 4'hD,
    4'h3, 4'hE, 4'hF, 4'h8, 4'h4, 4'h7, 4'h1, 4'h2
  };

  // present bit permutation, entry i is the destination of source bit i
  localparam bitIdx_t PermIdx [64] = '{
    6'd0,  6'd16, 6'd32, 6'd48, 6'd1,  6'd17, 6'd33, 6'd49,
    6'd2,  6'd18, 6'd34, 6'd50, 6'd3,  6'd19, 6'd35, 6'd51,
    6'd4,  6'd20, 6'd36, 6'd52, 6'd5,  6'd21, 6'd37, 6'd53,
    6'd6,  6'd22, 6'd38, 6'd54, 6'd7,  6'd23, 6'd39, 6'd55,
    6'd8,  6'd24, 6'd40, 6'd56, 6'd9,  6'd25, 6'd41, 6'd57,
    6'd10, 6'd26, 6'd42, 6'd58, 6'd11, 6'd27, 6'd43, 6'd59,
    6'd12, 6'd28, 6'd44, 6'd60, 6'd13, 6'd29, 6'd45, 6'd61,
    6'd14, 6'd30, 6'd46, 6'd62, 6'd15, 6'd31, 6'd47, 6'd63
  };

  //////////////////////////////
  // victim selection
  //////////////////////////////

  // cache associativity
  localparam int unsigned NumWays = 8;

  // one valid bit per way, bit 0 is way 0
  typedef logic [NumWays-1:0] wayMask_t;
  typedef logic [$clog2(NumWays)-1:0] wayIdx_t;

  // result of one replacement request
  typedef struct packed {
    logic    valid;
    wayIdx_t way;
    // victim was an empty way, not a random pick
    logic    fromInvalid;
  } victim_t;

endpackage

// File: src/galoisLfsr.sv
// 64-bit Galois LFSR, steps once per cycle with step_i high
// a seed load wins over a step in the same cycle
// a zero seed is replaced by LfsrRstSeed to avoid lock-up

`timescale 1ns/1ns

module galoisLfsr (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                step_i,
  input  logic                seedLoad_i,
  input  prngPkg::lfsrState_t seed_i,
  output prngPkg::lfsrState_t state_o
);

  import prngPkg::*;

  lfsrState_t stateD;
  lfsrState_t stateQ;
  lfsrState_t seedSafe;
  lfsrState_t stepped;

  // zero-seed guard
  assign seedSafe = (seed_i == '0) ? LfsrRstSeed : seed_i;

  // shift right, fold the taps back in when a one falls out of bit 0
  assign stepped = (stateQ >> 1) ^ ({LfsrWidth{stateQ[0]}} & LfsrMask);

  always_comb begin
    stateD = stateQ;
    if (seedLoad_i) begin
      stateD = seedSafe;
    end else if (step_i) begin
      stateD = stepped;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stateQ <= LfsrRstSeed;
    end else begin
      stateQ <= stateD;
    end
  end

  assign state_o = stateQ;

  //////////////////////////////
  // assertions
  //////////////////////////////

  // neither seed loads nor steps may ever reach the lock-up state
  stateNeverZero: assert property (
    @(posedge clk_i) disable iff (!rst_ni) stateQ != '0
  ) else $error("lfsr reached the all-zero state");

endmodule

// File: src/presentScrambler.sv
// scrambles the LFSR state with CipherLayers present-style rounds
// each round is an sbox layer followed by the bit permutation, no key
// the result is registered on step_i, from the state before that step
// after reset the scrambled word reads zero until the first step

`timescale 1ns/1ns

module presentScrambler (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                step_i,
  input  prngPkg::lfsrState_t state_i,
  output prngPkg::lfsrState_t word_o
);

  import prngPkg::*;

  //////////////////////////////
  // round functions
  //////////////////////////////

  // substitute all sixteen nibbles through the sbox
  function automatic lfsrState_t sboxLayer(lfsrState_t in);
    lfsrState_t res;
    res = '0;
    for (int unsigned n = 0; n < LfsrWidth / 4; n++) begin
      res[n*4 +: 4] = Sbox4[in[n*4 +: 4]];
    end
    return res;
  endfunction

  // move each source bit to its permuted position
  function automatic lfsrState_t permLayer(lfsrState_t in);
    lfsrState_t res;
    res = '0;
    for (int unsigned b = 0; b < LfsrWidth; b++) begin
      res[PermIdx[b]] = in[b];
    end
    return res;
  endfunction

  //////////////////////////////
  // datapath
  //////////////////////////////

  lfsrState_t cipherWord;
  lfsrState_t wordQ;

  // unrolled rounds, purely combinational
  always_comb begin
    lfsrState_t tmp;
    tmp = state_i;
    for (int unsigned r = 0; r < CipherLayers; r++) begin
      tmp = permLayer(sboxLayer(tmp));
    end
    cipherWord = tmp;
  end

  // output register, holds while no request comes in
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wordQ <= '0;
    end else if (step_i) begin
      wordQ <= cipherWord;
    end
  end

  assign word_o = wordQ;

endmodule

// File: src/victimSelect.sv
// picks the victim way of an 8-way set on each request
// an invalid way always wins, lowest index first
// with a full set the low bits of the scrambled word pick the way
// the result is registered, valid is a one-cycle pulse after req_i

`timescale 1ns/1ns

module victimSelect (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  input  prngPkg::wayMask_t   validWays_i,
  input  prngPkg::lfsrState_t randWord_i,
  output prngPkg::victim_t    victim_o
);

  import prngPkg::*;

  logic    anyInvalid;
  wayIdx_t firstInvalid;
  victim_t victimD;
  victim_t victimQ;

  // priority encoder, scan downwards so the lowest empty way ends up last
  always_comb begin
    firstInvalid = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (!validWays_i[w]) begin
        firstInvalid = wayIdx_t'(w);
      end
    end
  end

  assign anyInvalid = ~&validWays_i;

  always_comb begin
    victimD = victimQ;
    // valid only ever lasts one cycle
    victimD.valid = req_i;
    if (req_i) begin
      victimD.fromInvalid = anyInvalid;
      // random pick uses the low bits of the word before this edge
      victimD.way = anyInvalid ? firstInvalid : wayIdx_t'(randWord_i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      victimQ <= '0;
    end else begin
      victimQ <= victimD;
    end
  end

  assign victim_o = victimQ;

  // a victim flagged as empty must point at a zero bit of the sampled mask
  fromInvalidHolds: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_i |=> !victimQ.fromInvalid ||
              |(~$past(validWays_i) & (wayMask_t'(1) << victimQ.way))
  ) else $error("victim flagged fromInvalid was valid in the sampled mask");

endmodule

// File: src/randomVictimUnit.sv
// random victim picker for an 8-way set-associative cache
// one request per cycle, no back-pressure, every request gets a result
// randWord_o and the victim both update one edge after req_i

`timescale 1ns/1ns

module randomVictimUnit (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  input  logic                seedLoad_i,
  input  prngPkg::lfsrState_t seed_i,
  input  prngPkg::wayMask_t   validWays_i,
  output prngPkg::lfsrState_t randWord_o,
  output logic                victimValid_o,
  output prngPkg::wayIdx_t    victimWay_o,
  output logic                victimFromInvalid_o
);

  import prngPkg::*;

  lfsrState_t lfsrState;
  lfsrState_t scrambled;
  victim_t    victim;

  // the request strobe advances both the lfsr and the scrambler
  galoisLfsr u_galoisLfsr (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .step_i     (req_i),
    .seedLoad_i (seedLoad_i),
    .seed_i     (seed_i),
    .state_o    (lfsrState)
  );

  presentScrambler u_presentScrambler (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .step_i  (req_i),
    .state_i (lfsrState),
    .word_o  (scrambled)
  );

  victimSelect u_victimSelect (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .validWays_i (validWays_i),
    .randWord_i  (scrambled),
    .victim_o    (victim)
  );

  assign randWord_o          = scrambled;
  assign victimValid_o       = victim.valid;
  assign victimWay_o         = victim.way;
  assign victimFromInvalid_o = victim.fromInvalid;

endmodule

// File: verif/tb_randomVictimUnit.sv
// testbench for the random victim unit with one golden line per clock cycle
// expected values come from a local model of the lfsr and cipher rules
// golden lines may also pin fixed expected values from the offline model
// must be run from the project root so the golden file path resolves

`timescale 1ns/1ns

module tb_randomVictimUnit;

  import prngPkg::*;

  localparam int MaxLines = 64;
  localparam string GoldenFile = "verif/prng_golden.txt";

  // present sbox for the 4-bit substitution
  localparam logic [3:0] SboxRef [16] = '{
    4'hC, 4'h5, 4'h6, 4'hB, 4'h9, 4'h0, 4'hA, 4'hD,
    4'h3, 4'hE, 4'hF, 4'h8, 4'h4, 4'h7, 4'h1, 4'h2
  };

  logic       clk;
  logic       rstN;
  logic       req;
  logic       seedLoad;
  lfsrState_t seed;
  wayMask_t   validWays;
  lfsrState_t randWord;
  logic       victimValid;
  wayIdx_t    victimWay;
  logic       victimFromInvalid;

  // golden line storage
  logic [8*24-1:0] nameMem [MaxLines];
  logic            reqMem [MaxLines];
  logic            loadMem [MaxLines];
  lfsrState_t      seedMem [MaxLines];
  wayMask_t        maskMem [MaxLines];
  logic            rndMem [MaxLines];
  logic [1:0]      flagMem [MaxLines];
  lfsrState_t      expRandMem [MaxLines];
  wayIdx_t         expWayMem [MaxLines];
  logic            expInvMem [MaxLines];

  int numLines;
  int cycles;
  int cycleLimit;
  int checks;
  int errors;
  int testChecks;
  int testErrors;
  int seedVar;

  // reference model state
  lfsrState_t modelState;
  lfsrState_t modelWord;

  randomVictimUnit u_randomVictimUnit (
    .clk_i               (clk),
    .rst_ni              (rstN),
    .req_i               (req),
    .seedLoad_i          (seedLoad),
    .seed_i              (seed),
    .validWays_i         (validWays),
    .randWord_o          (randWord),
    .victimValid_o       (victimValid),
    .victimWay_o         (victimWay),
    .victimFromInvalid_o (victimFromInvalid)
  );

  //////////////////////////////
  // clock and timeout
  //////////////////////////////

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycleLimit) begin
      $display("timeout: run did not finish within %0d cycles", cycleLimit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  // one galois shift with the taps folded back when bit 0 falls out
  function automatic lfsrState_t lfsrAdvance(lfsrState_t s);
    lfsrState_t n;
    n = {1'b0, s[63:1]};
    if (s[0]) begin
      n = n ^ LfsrMask;
    end
    return n;
  endfunction

  // sbox on every nibble and then bit i moves to 16*(i mod 4) + i/4
  function automatic lfsrState_t applyCipher(lfsrState_t s);
    lfsrState_t t;
    lfsrState_t p;
    t = s;
    for (int r = 0; r < CipherLayers; r++) begin
      for (int n = 0; n < 16; n++) begin
        t[n*4 +: 4] = SboxRef[t[n*4 +: 4]];
      end
      p = '0;
      for (int i = 0; i < 64; i++) begin
        p[16 * (i % 4) + i / 4] = t[i];
      end
      t = p;
    end
    return t;
  endfunction

  // first cleared bit of the mask searched upwards from way 0
  function automatic wayIdx_t lowestZero(wayMask_t m);
    wayIdx_t r;
    bit      found;
    r = '0;
    found = 1'b0;
    for (int w = 0; w < 8; w++) begin
      if (!found && !m[w]) begin
        r = w[2:0];
        found = 1'b1;
      end
    end
    return r;
  endfunction

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic compareValue(input logic [8*24-1:0] testName, input string what,
                              input logic [63:0] expVal, input logic [63:0] actVal);
    checks++;
    testChecks++;
    assert (expVal === actVal) else begin
      $display("[FAIL] %0s %0s expected %h actual %h", testName, what, expVal, actVal);
      errors++;
      testErrors++;
    end
  endtask

  task automatic loadGolden(output bit ok);
    int fd;
    int cnt;
    logic [8*200-1:0] lineBuf;
    logic [8*24-1:0] nm;
    logic [63:0] f [9];
    ok = 1'b0;
    numLines = 0;
    fd = $fopen(GoldenFile, "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!$feof(fd) && numLines < MaxLines) begin
        lineBuf = '0;
        cnt = $fgets(lineBuf, fd);
        cnt = $sscanf(lineBuf, "%s %h %h %h %h %h %h %h %h %h", nm,
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
        // comment and blank lines fail to scan all ten fields
        if (cnt == 10) begin
          nameMem[numLines]    = nm;
          reqMem[numLines]     = f[0][0];
          loadMem[numLines]    = f[1][0];
          seedMem[numLines]    = f[2];
          maskMem[numLines]    = f[3][7:0];
          rndMem[numLines]     = f[4][0];
          flagMem[numLines]    = f[5][1:0];
          expRandMem[numLines] = f[6];
          expWayMem[numLines]  = f[7][2:0];
          expInvMem[numLines]  = f[8][0];
          numLines++;
        end
      end
      $fclose(fd);
    end
  endtask

  // drive one golden line and check the outputs after the next edge
  task automatic runLine(input int idx);
    int         rndIdx;
    wayMask_t   mask;
    lfsrState_t expWord;
    wayIdx_t    expWay;
    logic       expInv;
    mask = maskMem[idx];
    if (rndMem[idx]) begin
      mask = wayMask_t'($random(seedVar));
      if (mask == '1) begin
        rndIdx = $unsigned($random(seedVar)) % NumWays;
        mask[rndIdx[2:0]] = 1'b0;
      end
    end
    req       = reqMem[idx];
    seedLoad  = loadMem[idx];
    seed      = seedMem[idx];
    validWays = mask;
    expWord = modelWord;
    expWay  = '0;
    expInv  = 1'b0;
    if (reqMem[idx]) begin
      expWord = applyCipher(modelState);
      expInv  = (mask != '1);
      expWay  = expInv ? lowestZero(mask) : modelWord[2:0];
    end
    if (loadMem[idx]) begin
      modelState = (seedMem[idx] == '0) ? LfsrRstSeed : seedMem[idx];
    end else if (reqMem[idx]) begin
      modelState = lfsrAdvance(modelState);
    end
    modelWord = expWord;
    @(posedge clk);
    #5;
    compareValue(nameMem[idx], "randWord", expWord, randWord);
    compareValue(nameMem[idx], "victimValid", 64'(reqMem[idx]), 64'(victimValid));
    if (reqMem[idx]) begin
      compareValue(nameMem[idx], "victimWay", 64'(expWay), 64'(victimWay));
      compareValue(nameMem[idx], "fromInvalid", 64'(expInv), 64'(victimFromInvalid));
    end
    if (flagMem[idx][0]) begin
      compareValue(nameMem[idx], "golden randWord", expRandMem[idx], randWord);
    end
    if (flagMem[idx][1]) begin
      compareValue(nameMem[idx], "golden victimWay", 64'(expWayMem[idx]), 64'(victimWay));
      compareValue(nameMem[idx], "golden fromInvalid", 64'(expInvMem[idx]),
                   64'(victimFromInvalid));
    end
    #5;
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    bit ok;
    rstN       = 1'b0;
    req        = 1'b0;
    seedLoad   = 1'b0;
    seed       = '0;
    validWays  = '1;
    cycles     = 0;
    cycleLimit = 2 * MaxLines + 20;
    checks     = 0;
    errors     = 0;
    testChecks = 0;
    testErrors = 0;
    seedVar    = 13;
    modelState = LfsrRstSeed;
    modelWord  = '0;
    loadGolden(ok);
    if (!ok) begin
      $display("cannot open golden file %0s", GoldenFile);
      $display("TESTBENCH FAILED");
      $finish;
    end else begin
      cycleLimit = 2 * numLines + 20;
      repeat (5) @(posedge clk);
      #10;
      rstN = 1'b1;
      // reset values before any request
      compareValue("after_reset", "randWord", 64'd0, randWord);
      compareValue("after_reset", "victimValid", 64'd0, 64'(victimValid));
      $display("test after_reset finished: %0d checks, %0d errors", testChecks, testErrors);
      testChecks = 0;
      testErrors = 0;
      for (int i = 0; i < numLines; i++) begin
        runLine(i);
        if (i == numLines - 1 || nameMem[i + 1] != nameMem[i]) begin
          $display("test %0s finished: %0d checks, %0d errors",
                   nameMem[i], testChecks, testErrors);
          testChecks = 0;
          testErrors = 0;
        end
      end
      $display("summary: %0d lines, %0d checks, %0d errors", numLines, checks, errors);
      if (errors == 0 && numLines > 0) begin
        $display("TESTBENCH PASSED");
      end else begin
        $display("TESTBENCH FAILED");
      end
      $finish;
    end
  end

endmodule

// File: flist.f
src/prngPkg.sv
src/galoisLfsr.sv
src/presentScrambler.sv
src/victimSelect.sv
src/randomVictimUnit.sv
verif/tb_randomVictimUnit.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the random victim unit testbench with Verilator
# run from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_randomVictimUnit

verilator --binary --timing --assert -f flist.f --top-module "$TOP" -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

./obj_dir/V"$TOP" | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
  echo "simulation exited with an error status"
  exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
  echo "run ok"
  exit 0
else
  echo "run reported a failure, see $LOG"
  exit 1
fi

// File: verif/prng_golden.txt
# name req seedLoad seed(hex) validWays(hex) rndMask chkFlags expRandWord expWay expFromInvalid
# chkFlags bit0 compares randWord with the file, bit1 compares way and fromInvalid
reset_seq 1 0 0000000000000000 ff 0 3 ff0fff0f00f00000 0 0
reset_seq 1 0 0000000000000000 ff 0 2 0000000000000000 0 0
reset_seq 1 0 0000000000000000 ff 0 0 0000000000000000 0 0
reset_seq 1 0 0000000000000000 ff 0 0 0000000000000000 0 0
reset_seq 1 0 0000000000000000 ff 0 0 0000000000000000 0 0
hold 0 0 0000000000000000 ff 0 0 0000000000000000 0 0
hold 0 0 0000000000000000 ff 0 0 0000000000000000 0 0
hold 0 0 0000000000000000 ff 0 0 0000000000000000 0 0
hold 1 0 0000000000000000 ff 0 0 0000000000000000 0 0
hold 1 0 0000000000000000 ff 0 0 0000000000000000 0 0
seed_load 0 1 0123456789abcdef ff 0 0 0000000000000000 0 0
seed_load 1 0 0000000000000000 ff 0 0 0000000000000000 0 0
seed_load 1 0 0000000000000000 ff 0 0 0000000000000000 0 0
seed_load 1 1 fedcba9876543210 ff 0 0 0000000000000000 0 0
seed_load 1 0 0000000000000000 ff 0 0 0000000000000000 0 0
zero_seed 0 1 0000000000000000 ff 0 0 0000000000000000 0 0
zero_seed 1 0 0000000000000000 ff 0 1 ff0fff0f00f00000 0 0
zero_seed 1 0 0000000000000000 ff 0 2 0000000000000000 0 0
invalid_first 1 0 0000000000000000 fe 0 2 0000000000000000 0 1
invalid_first 1 0 0000000000000000 7f 0 2 0000000000000000 7 1
invalid_first 1 0 0000000000000000 f3 0 2 0000000000000000 2 1
invalid_first 1 0 0000000000000000 ef 0 2 0000000000000000 4 1
invalid_first 1 0 0000000000000000 00 1 0 0000000000000000 0 0
invalid_first 1 0 0000000000000000 00 1 0 0000000000000000 0 0
invalid_first 1 0 0000000000000000 00 1 0 0000000000000000 0 0
invalid_first 1 0 0000000000000000 00 1 0 0000000000000000 0 0
random_pick 1 0 0000000000000000 ff 0 0 0000000000000000 0 0
random_pick 1 0 0000000000000000 ff 0 0 0000000000000000 0 0
random_pick 1 0 0000000000000000 ff 0 0 0000000000000000 0 0
valid_pulse 1 0 0000000000000000 ff 0 0 0000000000000000 0 0
valid_pulse 0 0 0000000000000000 ff 0 0 0000000000000000 0 0
valid_pulse 1 0 0000000000000000 ff 0 0 0000000000000000 0 0
valid_pulse 1 0 0000000000000000 f0 0 0 0000000000000000 0 0
valid_pulse 0 0 0000000000000000 ff 0 0 0000000000000000 0 0
